// File: design/mips_pkg.sv
// Shared types for the MIPS32 subset core; addresses are byte addresses, word aligned only
`default_nettype none

package mips_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;
    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;
    localparam int IMEM_AW    = $clog2(IMEM_DEPTH);
    localparam int DMEM_AW    = $clog2(DMEM_DEPTH);

    // Primary opcodes
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct field
    localparam logic [5:0] FN_SLL  = 6'h00;
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    typedef enum logic [2:0] {ADD, SUB, AND, OR, SLT, SLL} alu_op_e;

    typedef enum logic [1:0] {REG, MEM, WB} fwd_sel_e;

    typedef struct packed {
        logic    reg_wr;
        logic    mem_rd;
        logic    mem_wr;
        logic    mem_to_reg;
        logic    branch;
        alu_op_e alu_op;
        logic    alu_src_imm;
        logic    alu_src_shamt;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc_plus4;
        logic [XLEN-1:0] instr;
    } if_id_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rs;
        logic [REG_ADDR_W-1:0] rt;
        logic [REG_ADDR_W-1:0] rd_dest;
        logic [XLEN-1:0]       rs_data;
        logic [XLEN-1:0]       rt_data;
        logic [XLEN-1:0]       imm;
        logic [4:0]            shamt;
        logic [XLEN-1:0]       branch_target;
    } id_ex_t;

    typedef struct packed {
        logic                  valid;
        ctrl_t                 ctrl;
        logic [REG_ADDR_W-1:0] rd_dest;
        logic [XLEN-1:0]       alu_res;
        logic [XLEN-1:0]       store_data;
    } ex_mem_t;

    typedef struct packed {
        logic                  valid;
        logic                  reg_wr;
        logic [REG_ADDR_W-1:0] rd_dest;
        logic [XLEN-1:0]       wr_data;
    } mem_wb_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] rd;
        logic [XLEN-1:0]       data;
    } wb_t;

endpackage

`default_nettype wire

// File: design/mips_stage_reg.sv
// Pipeline register for any packed payload; flush zeroes all bits and overrides hold
`timescale 1ns/1ps
`default_nettype none

module mips_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n_i,
    input  logic     hold_i,
    input  logic     flush_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            q_o <= '0;
        end else if (flush_i) begin
            q_o <= '0;
        end else if (!hold_i) begin
            q_o <= d_i;
        end
    end

endmodule

`default_nettype wire

// File: design/mips_fetch.sv
// Fetch stage; imem_waddr_i is a byte address, only word bits inside IMEM_DEPTH are decoded
`timescale 1ns/1ps
`default_nettype none

module mips_fetch import mips_pkg::*; (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            hold_i,
    input  logic            redirect_i,
    input  logic [XLEN-1:0] redirect_pc_i,
    input  logic            imem_we_i,
    input  logic [XLEN-1:0] imem_waddr_i,
    input  logic [XLEN-1:0] imem_wdata_i,
    output if_id_t          if_o
);

    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] imem [IMEM_DEPTH];

    assign pc_plus4 = pc + XLEN'(4);

    // Redirect never coincides with a stall, so its order against hold is free
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc <= '0;
        end else if (redirect_i) begin
            pc <= redirect_pc_i;
        end else if (!hold_i) begin
            pc <= pc_plus4;
        end
    end

    always_ff @(posedge clk) begin
        if (imem_we_i) begin
            imem[imem_waddr_i[IMEM_AW+1:2]] <= imem_wdata_i;
        end
    end

    always_comb begin
        if_o.valid    = 1'b1;
        if_o.pc_plus4 = pc_plus4;
        if_o.instr    = imem[pc[IMEM_AW+1:2]];
    end

endmodule

`default_nettype wire

// File: design/mips_decode.sv
// Instruction decoder; unknown opcodes and functs give an all-zero control bundle (a nop)
`timescale 1ns/1ps
`default_nettype none

module mips_decode import mips_pkg::*; (
    input  logic [XLEN-1:0]       instr_i,
    output ctrl_t                 ctrl_o,
    output logic [REG_ADDR_W-1:0] rs_o,
    output logic [REG_ADDR_W-1:0] rt_o,
    output logic [REG_ADDR_W-1:0] rd_dest_o,
    output logic [XLEN-1:0]       imm_o,
    output logic [4:0]            shamt_o,
    output logic                  jump_o,
    output logic [25:0]           jump_target_o
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    logic [15:0] imm16;

    assign opcode = instr_i[31:26];
    assign funct  = instr_i[5:0];
    assign imm16  = instr_i[15:0];

    assign rs_o          = instr_i[25:21];
    assign rt_o          = instr_i[20:16];
    assign rd_dest_o     = (opcode == OP_RTYPE) ? instr_i[15:11] : instr_i[20:16];
    assign imm_o         = {{(XLEN-16){imm16[15]}}, imm16};
    assign shamt_o       = instr_i[10:6];
    assign jump_o        = (opcode == OP_J);
    assign jump_target_o = instr_i[25:0];

    always_comb begin
        ctrl_o = '0;
        case (opcode)
            OP_RTYPE: begin
                ctrl_o.reg_wr = 1'b1;
                case (funct)
                    FN_ADDU: ctrl_o.alu_op = ADD;
                    FN_SUBU: ctrl_o.alu_op = SUB;
                    FN_AND:  ctrl_o.alu_op = AND;
                    FN_OR:   ctrl_o.alu_op = OR;
                    FN_SLT:  ctrl_o.alu_op = SLT;
                    FN_SLL: begin
                        ctrl_o.alu_op        = SLL;
                        ctrl_o.alu_src_shamt = 1'b1;
                    end
                    default: ctrl_o.reg_wr = 1'b0;
                endcase
            end
            OP_ADDIU: begin
                ctrl_o.reg_wr      = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
            end
            OP_LW: begin
                ctrl_o.reg_wr      = 1'b1;
                ctrl_o.mem_rd      = 1'b1;
                ctrl_o.mem_to_reg  = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
            end
            OP_SW: begin
                ctrl_o.mem_wr      = 1'b1;
                ctrl_o.alu_src_imm = 1'b1;
            end
            // Compare by subtraction, taken on zero
            OP_BEQ: begin
                ctrl_o.branch = 1'b1;
                ctrl_o.alu_op = SUB;
            end
            default: begin
                ctrl_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: design/mips_regfile.sv
// Register file with write-through reads; $0 reads zero and ignores writes
`timescale 1ns/1ps
`default_nettype none

module mips_regfile import mips_pkg::*; (
    input  logic                  clk,
    input  logic                  arst_n_i,
    input  logic                  we_i,
    input  logic [REG_ADDR_W-1:0] waddr_i,
    input  logic [XLEN-1:0]       wdata_i,
    input  logic [REG_ADDR_W-1:0] raddr1_i,
    input  logic [REG_ADDR_W-1:0] raddr2_i,
    output logic [XLEN-1:0]       rdata1_o,
    output logic [XLEN-1:0]       rdata2_o
);

    logic [XLEN-1:0] regs [2**REG_ADDR_W];

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            regs <= '{default: '0};
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // Same-cycle write is visible to issue
    assign rdata1_o = (raddr1_i == '0) ? '0 :
                      (we_i && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (raddr2_i == '0) ? '0 :
                      (we_i && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

`default_nettype wire

// File: design/mips_alu.sv
// 32-bit ALU; SLT compares signed, SLL shifts b_i left by a_i[4:0]
`timescale 1ns/1ps
`default_nettype none

module mips_alu import mips_pkg::*; (
    input  logic [XLEN-1:0] a_i,
    input  logic [XLEN-1:0] b_i,
    input  alu_op_e         op_i,
    output logic [XLEN-1:0] res_o,
    output logic            zero_o
);

    logic lt;

    assign lt = $signed(a_i) < $signed(b_i);

    always_comb begin
        case (op_i)
            ADD:     res_o = a_i + b_i;
            SUB:     res_o = a_i - b_i;
            AND:     res_o = a_i & b_i;
            OR:      res_o = a_i | b_i;
            SLT:     res_o = {{(XLEN-1){1'b0}}, lt};
            SLL:     res_o = b_i << a_i[4:0];
            default: res_o = '0;
        endcase
    end

    assign zero_o = (res_o == '0);

endmodule

`default_nettype wire

// File: design/mips_data_mem.sv
// Word data RAM, no reset contents; addr_i is a byte address, low two bits ignored
`timescale 1ns/1ps
`default_nettype none

module mips_data_mem import mips_pkg::*; (
    input  logic            clk,
    input  logic            we_i,
    input  logic [XLEN-1:0] addr_i,
    input  logic [XLEN-1:0] wdata_i,
    output logic [XLEN-1:0] rdata_o
);

    logic [XLEN-1:0]    ram [DMEM_DEPTH];
    logic [DMEM_AW-1:0] widx;

    assign widx = addr_i[DMEM_AW+1:2];

    always_ff @(posedge clk) begin
        if (we_i) begin
            ram[widx] <= wdata_i;
        end
    end

    assign rdata_o = ram[widx];

endmodule

`default_nettype wire

// File: design/mips_hazard.sv
// Hazard unit; a jump is ignored while a load-use stall holds it in issue
`timescale 1ns/1ps
`default_nettype none

module mips_hazard import mips_pkg::*; (
    input  logic [REG_ADDR_W-1:0] id_rs_i,
    input  logic [REG_ADDR_W-1:0] id_rt_i,
    input  logic                  id_jump_i,
    input  id_ex_t                ex_i,
    input  logic                  ex_taken_i,
    input  ex_mem_t               mem_i,
    input  mem_wb_t               wb_i,
    output logic                  stall_o,
    output logic                  flush_if_id_o,
    output logic                  flush_id_ex_o,
    output fwd_sel_e              fwd_a_o,
    output fwd_sel_e              fwd_b_o
);

    // Younger stage wins since it holds the newer value
    function automatic fwd_sel_e pick_src(input logic [REG_ADDR_W-1:0] src,
                                          input ex_mem_t m, input mem_wb_t w);
        fwd_sel_e sel;
        if (m.valid && m.ctrl.reg_wr && m.rd_dest != '0 && m.rd_dest == src) begin
            sel = MEM;
        end else if (w.valid && w.reg_wr && w.rd_dest != '0 && w.rd_dest == src) begin
            sel = WB;
        end else begin
            sel = REG;
        end
        return sel;
    endfunction

    assign fwd_a_o = pick_src(ex_i.rs, mem_i, wb_i);
    assign fwd_b_o = pick_src(ex_i.rt, mem_i, wb_i);

    assign stall_o = ex_i.valid && ex_i.ctrl.mem_rd && ex_i.rd_dest != '0 &&
                     (ex_i.rd_dest == id_rs_i || ex_i.rd_dest == id_rt_i);

    assign flush_if_id_o = ex_taken_i || (id_jump_i && !stall_o);
    assign flush_id_ex_o = ex_taken_i || stall_o;

endmodule

`default_nettype wire

// File: design/mips_core.sv
// Five-stage MIPS32 subset core; no delay slots, imem is written only through the load port
`timescale 1ns/1ps
`default_nettype none

module mips_core import mips_pkg::*; (
    input  logic            clk,
    input  logic            arst_n_i,
    input  logic            imem_we_i,
    input  logic [XLEN-1:0] imem_waddr_i,
    input  logic [XLEN-1:0] imem_wdata_i,
    output wb_t             wb_o
);

    if_id_t                if_d;
    if_id_t                if_q;
    id_ex_t                id_d;
    id_ex_t                id_q;
    ex_mem_t               ex_d;
    ex_mem_t               ex_q;
    mem_wb_t               mem_d;
    mem_wb_t               mem_q;
    logic                  stall;
    logic                  flush_if_id;
    logic                  flush_id_ex;
    fwd_sel_e              fwd_a;
    fwd_sel_e              fwd_b;
    ctrl_t                 dec_ctrl;
    logic [REG_ADDR_W-1:0] dec_rs;
    logic [REG_ADDR_W-1:0] dec_rt;
    logic [REG_ADDR_W-1:0] dec_rd;
    logic [XLEN-1:0]       dec_imm;
    logic [4:0]            dec_shamt;
    logic                  dec_jump;
    logic [25:0]           dec_target;
    logic [XLEN-1:0]       rs_data;
    logic [XLEN-1:0]       rt_data;
    logic [XLEN-1:0]       redirect_pc;
    logic [XLEN-1:0]       opnd_a;
    logic [XLEN-1:0]       opnd_b;
    logic [XLEN-1:0]       alu_a;
    logic [XLEN-1:0]       alu_b;
    logic [XLEN-1:0]       alu_res;
    logic                  alu_zero;
    logic                  ex_taken;
    logic [XLEN-1:0]       dmem_rdata;

    // Fetch
    mips_fetch u_fetch (
        .clk           (clk),
        .arst_n_i      (arst_n_i),
        .hold_i        (stall),
        .redirect_i    (flush_if_id),
        .redirect_pc_i (redirect_pc),
        .imem_we_i     (imem_we_i),
        .imem_waddr_i  (imem_waddr_i),
        .imem_wdata_i  (imem_wdata_i),
        .if_o          (if_d)
    );

    mips_stage_reg #(.payload_t(if_id_t)) u_if_id (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (stall),
        .flush_i  (flush_if_id),
        .d_i      (if_d),
        .q_o      (if_q)
    );

    // Issue
    mips_decode u_decode (
        .instr_i       (if_q.instr),
        .ctrl_o        (dec_ctrl),
        .rs_o          (dec_rs),
        .rt_o          (dec_rt),
        .rd_dest_o     (dec_rd),
        .imm_o         (dec_imm),
        .shamt_o       (dec_shamt),
        .jump_o        (dec_jump),
        .jump_target_o (dec_target)
    );

    mips_regfile u_regfile (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .we_i     (wb_o.we),
        .waddr_i  (wb_o.rd),
        .wdata_i  (wb_o.data),
        .raddr1_i (dec_rs),
        .raddr2_i (dec_rt),
        .rdata1_o (rs_data),
        .rdata2_o (rt_data)
    );

    always_comb begin
        id_d.valid         = if_q.valid;
        id_d.ctrl          = dec_ctrl;
        id_d.rs            = dec_rs;
        id_d.rt            = dec_rt;
        id_d.rd_dest       = dec_rd;
        id_d.rs_data       = rs_data;
        id_d.rt_data       = rt_data;
        id_d.imm           = dec_imm;
        id_d.shamt         = dec_shamt;
        id_d.branch_target = if_q.pc_plus4 + {dec_imm[XLEN-3:0], 2'b00};
    end

    // Taken branch in execute outranks a jump in issue
    assign redirect_pc = ex_taken ? id_q.branch_target :
                         {if_q.pc_plus4[XLEN-1:28], dec_target, 2'b00};

    mips_hazard u_hazard (
        .id_rs_i       (dec_rs),
        .id_rt_i       (dec_rt),
        .id_jump_i     (if_q.valid & dec_jump),
        .ex_i          (id_q),
        .ex_taken_i    (ex_taken),
        .mem_i         (ex_q),
        .wb_i          (mem_q),
        .stall_o       (stall),
        .flush_if_id_o (flush_if_id),
        .flush_id_ex_o (flush_id_ex),
        .fwd_a_o       (fwd_a),
        .fwd_b_o       (fwd_b)
    );

    mips_stage_reg #(.payload_t(id_ex_t)) u_id_ex (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .flush_i  (flush_id_ex),
        .d_i      (id_d),
        .q_o      (id_q)
    );

    // Execute
    always_comb begin
        case (fwd_a)
            MEM:     opnd_a = ex_q.alu_res;
            WB:      opnd_a = mem_q.wr_data;
            default: opnd_a = id_q.rs_data;
        endcase
        case (fwd_b)
            MEM:     opnd_b = ex_q.alu_res;
            WB:      opnd_b = mem_q.wr_data;
            default: opnd_b = id_q.rt_data;
        endcase
    end

    assign alu_a = id_q.ctrl.alu_src_shamt ? {{(XLEN-5){1'b0}}, id_q.shamt} : opnd_a;
    assign alu_b = id_q.ctrl.alu_src_imm ? id_q.imm : opnd_b;

    mips_alu u_alu (
        .a_i    (alu_a),
        .b_i    (alu_b),
        .op_i   (id_q.ctrl.alu_op),
        .res_o  (alu_res),
        .zero_o (alu_zero)
    );

    assign ex_taken = id_q.valid & id_q.ctrl.branch & alu_zero;

    always_comb begin
        ex_d.valid      = id_q.valid;
        ex_d.ctrl       = id_q.ctrl;
        ex_d.rd_dest    = id_q.rd_dest;
        ex_d.alu_res    = alu_res;
        ex_d.store_data = opnd_b;
    end

    mips_stage_reg #(.payload_t(ex_mem_t)) u_ex_mem (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .flush_i  (1'b0),
        .d_i      (ex_d),
        .q_o      (ex_q)
    );

    // Memory
    mips_data_mem u_data_mem (
        .clk     (clk),
        .we_i    (ex_q.valid & ex_q.ctrl.mem_wr),
        .addr_i  (ex_q.alu_res),
        .wdata_i (ex_q.store_data),
        .rdata_o (dmem_rdata)
    );

    always_comb begin
        mem_d.valid   = ex_q.valid;
        mem_d.reg_wr  = ex_q.ctrl.reg_wr;
        mem_d.rd_dest = ex_q.rd_dest;
        mem_d.wr_data = ex_q.ctrl.mem_to_reg ? dmem_rdata : ex_q.alu_res;
    end

    mips_stage_reg #(.payload_t(mem_wb_t)) u_mem_wb (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .hold_i   (1'b0),
        .flush_i  (1'b0),
        .d_i      (mem_d),
        .q_o      (mem_q)
    );

    // Writeback, reported the cycle before the commit edge
    assign wb_o.we   = mem_q.valid & mem_q.reg_wr & (mem_q.rd_dest != '0);
    assign wb_o.rd   = mem_q.rd_dest;
    assign wb_o.data = mem_q.wr_data;

endmodule

`default_nettype wire

// File: tb/tb_mips_core.sv
// Testbench for mips_core; run from the project root so that tb/mips_cases.mem is found
`timescale 1ns/1ps
`default_nettype none

module tb_mips_core import mips_pkg::*; ();

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 2;
    localparam int IDLE_CYCLES  = 20;
    localparam int CASE_DEPTH   = 256;
    localparam int PROG_BASE    = 'h10;
    localparam int EXP_BASE     = 'h40;
    localparam int WB_W         = $bits(wb_t);

    logic            clk;
    logic            arst_n;
    logic            imem_we;
    logic [XLEN-1:0] imem_waddr;
    logic [XLEN-1:0] imem_wdata;
    wb_t             wb;

    logic [WB_W-1:0] cases [CASE_DEPTH];
    logic [XLEN-1:0] prog_words [$];
    wb_t             exp_writes [$];
    int              n_prog;
    int              n_exp;
    int              exp_idx;
    logic            loaded;
    logic            checking;

    mips_core u_mips_core (
        .clk          (clk),
        .arst_n_i     (arst_n),
        .imem_we_i    (imem_we),
        .imem_waddr_i (imem_waddr),
        .imem_wdata_i (imem_wdata),
        .wb_o         (wb)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    task automatic abort_run();
        $display("SIMULATION FAILED");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic check_wb(input wb_t got, input wb_t want);
        if (got !== want) begin
            $display("mismatch at %0d ns: write %0d got we=%0b rd=%0d data=%08h",
                     $time, exp_idx, got.we, got.rd, got.data);
            $display("mismatch at %0d ns: write %0d expected we=%0b rd=%0d data=%08h",
                     $time, exp_idx, want.we, want.rd, want.data);
            abort_run();
        end
    endtask

    // wb_o holds a write during the cycle before its commit edge
    always @(posedge clk) begin
        if (checking && wb.we) begin
            if (exp_idx >= n_exp) begin
                $display("unexpected register write to $%0d with data %08h after the last one",
                         wb.rd, wb.data);
                abort_run();
            end else begin
                check_wb(wb, exp_writes[exp_idx]);
                exp_idx = exp_idx + 1;
            end
        end
    end

    // Watchdog scaled to program length
    initial begin
        wait (loaded === 1'b1);
        repeat (20 * n_prog + 100) @(posedge clk);
        $display("timeout: only %0d of the %0d expected register writes arrived",
                 exp_idx, n_exp);
        abort_run();
    end

    initial begin
        arst_n     = 1'b0;
        imem_we    = 1'b0;
        imem_waddr = '0;
        imem_wdata = '0;
        checking   = 1'b0;
        loaded     = 1'b0;
        exp_idx    = 0;

        $readmemh("tb/mips_cases.mem", cases);
        n_prog = int'(cases[0]);
        n_exp  = int'(cases[1]);
        if (n_prog == 0 || n_exp == 0) begin
            $display("case file tb/mips_cases.mem is missing or holds no program or writes");
            abort_run();
        end
        for (int i = 0; i < n_prog; i++) begin
            prog_words.push_back(cases[PROG_BASE + i][XLEN-1:0]);
        end
        for (int i = 0; i < n_exp; i++) begin
            exp_writes.push_back(wb_t'(cases[EXP_BASE + i]));
        end
        loaded = 1'b1;

        // Program goes in through the load port while the core sits in reset
        foreach (prog_words[i]) begin
            @(negedge clk);
            imem_we    = 1'b1;
            imem_waddr = XLEN'(i * 4);
            imem_wdata = prog_words[i];
        end
        @(negedge clk);
        imem_we = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        arst_n   = 1'b1;
        checking = 1'b1;

        wait (exp_idx == n_exp);
        // Quiet period catches writes past the end of the list
        repeat (IDLE_CYCLES) @(negedge clk);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/mips_cases.mem
// @00: program word count, expected write count. @10: program words from byte address 0.
// @40: expected register writes in order, as {we, rd[4:0], data[31:0]}.
@00
17
0D
@10
24010005    // 00 addiu $1, $0, 5
2402FFFD    // 04 addiu $2, $0, -3
00221821    // 08 addu  $3, $1, $2     both operands forwarded
00612023    // 0c subu  $4, $3, $1
0041282A    // 10 slt   $5, $2, $1
0024302A    // 14 slt   $6, $1, $4
00413824    // 18 and   $7, $2, $1
00A44025    // 1c or    $8, $5, $4
00014900    // 20 sll   $9, $1, 4
24200007    // 24 addiu $0, $1, 7      never reported
AC090010    // 28 sw    $9, 16($0)
8C0A0010    // 2c lw    $10, 16($0)
01415821    // 30 addu  $11, $10, $1   load-use stall
10270002    // 34 beq   $1, $7, +2     taken
240C0111    // 38 addiu $12, $0, 0x111 skipped
240D0222    // 3c addiu $13, $0, 0x222 skipped
10220001    // 40 beq   $1, $2, +1     not taken
240E0333    // 44 addiu $14, $0, 0x333
08000015    // 48 j     0x54
240F0444    // 4c addiu $15, $0, 0x444 skipped
24100555    // 50 addiu $16, $0, 0x555 skipped
016E8821    // 54 addu  $17, $11, $14
08000016    // 58 j     0x58
@40
2100000005
22FFFFFFFD
2300000002
24FFFFFFFD
2500000001
2600000000
2700000005
28FFFFFFFD
2900000050
2A00000050
2B00000055
2E00000333
3100000388

// File: verilog.f
design/mips_pkg.sv
design/mips_stage_reg.sv
design/mips_fetch.sv
design/mips_decode.sv
design/mips_regfile.sv
design/mips_alu.sv
design/mips_data_mem.sv
design/mips_hazard.sv
design/mips_core.sv
tb/tb_mips_core.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and passes only on the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_mips_core -f verilog.f

sim_out=$(./obj_dir/Vtb_mips_core 2>&1) || true
echo "$sim_out"

if grep -qx "SIMULATION PASSED" <<< "$sim_out"; then
    exit 0
else
    exit 1
fi
